/* src/tdu_csr_pkg.sv */
// CSR side definitions of the trigger debug unit
// Shared by the CSR front end and the mcontrol triggers

package tdu_csr_pkg;

    typedef logic [31:0] tdu_data_t;   // CSR and TDATA2 word
    typedef logic [2:0]  csr_offs_t;   // Offset inside the TDU CSR block

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_SET   = 2'd2,
        CMD_CLEAR = 2'd3
    } csr_cmd_e;

    // Register offsets
    localparam csr_offs_t OFFS_TSELECT = 3'd0;
    localparam csr_offs_t OFFS_TDATA1  = 3'd1;
    localparam csr_offs_t OFFS_TDATA2  = 3'd2;
    localparam csr_offs_t OFFS_TINFO   = 3'd4;

    // TDATA1 in mcontrol format
    // --------------------------------------------------
    localparam int TYPE_HI    = 31;
    localparam int TYPE_LO    = 28;
    localparam int DMODE_BIT  = 27;
    localparam int MASKMAX_HI = 26;
    localparam int MASKMAX_LO = 21;
    localparam int HIT_BIT    = 20;
    localparam int SELECT_BIT = 19;
    localparam int TIMING_BIT = 18;
    localparam int ACTION_HI  = 17;
    localparam int ACTION_LO  = 12;
    localparam int CHAIN_BIT  = 11;
    localparam int MATCH_HI   = 10;
    localparam int MATCH_LO   = 7;
    localparam int M_BIT      = 6;
    localparam int RSVD_HI    = 5;      // S, U and reserved bit
    localparam int RSVD_LO    = 3;
    localparam int EXEC_BIT   = 2;
    localparam int STORE_BIT  = 1;
    localparam int LOAD_BIT   = 0;

    // Fields that are not stored
    localparam logic [3:0] MCONTROL_TYPE = 4'd2;
    localparam logic [5:0] MASKMAX_VAL   = 6'd0;   // Exact match only
    localparam logic       SELECT_VAL    = 1'b0;   // Address compare
    localparam logic       TIMING_VAL    = 1'b0;   // Fire before execution
    localparam logic       CHAIN_VAL     = 1'b0;
    localparam logic [3:0] MATCH_VAL     = 4'd0;   // Equal compare
    localparam logic [2:0] RSVD_VAL      = 3'd0;

endpackage

/* src/tdu_trig_pkg.sv */
// Trigger side definitions of the trigger debug unit
// Used by the trigger bank and the top level monitor ports

package tdu_trig_pkg;

    // Virtual address seen on the instruction and data monitors
    typedef logic [31:0] mem_addr_t;

    // Action taken when a trigger fires
    // Only an action field of exactly 1 selects debug mode entry
    typedef enum logic {
        ACT_BREAK_EXC  = 1'b0,   // Breakpoint exception
        ACT_DEBUG_MODE = 1'b1    // Request to enter debug mode
    } trig_action_e;

endpackage

/* src/tdu_csr_if.sv */
// CSR front end of the trigger debug unit
// Holds TSELECT, forms write data and strobes, muxes read data

`timescale 1ns/1ps

module tdu_csr_if #(
    parameter int unsigned MTRIG_NUM = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic                                    csr_req_i,
    input  tdu_csr_pkg::csr_cmd_e                   csr_cmd_i,
    input  tdu_csr_pkg::csr_offs_t                  csr_addr_i,
    input  tdu_csr_pkg::tdu_data_t                  csr_wdata_i,
    output tdu_csr_pkg::tdu_data_t                  csr_rdata_o,

    input  tdu_csr_pkg::tdu_data_t [MTRIG_NUM-1:0]  tdata1_rd_i,   // Per trigger images
    input  tdu_csr_pkg::tdu_data_t [MTRIG_NUM-1:0]  tdata2_rd_i,
    output logic [MTRIG_NUM-1:0]                    tdata1_we_o,
    output logic [MTRIG_NUM-1:0]                    tdata2_we_o,
    output tdu_csr_pkg::tdu_data_t                  wr_data_o
);

    import tdu_csr_pkg::*;
    import tdu_trig_pkg::*;

    localparam int TSEL_W = (MTRIG_NUM > 1) ? $clog2(MTRIG_NUM) : 1;

    logic              wr_req;
    logic              wr_en;
    tdu_data_t         wr_data;
    logic              tsel_upd;
    logic [TSEL_W-1:0] tsel_q;
    logic [MTRIG_NUM-1:0] sel_onehot;

    // Read mux
    // --------------------------------------------------
    always_comb begin
        csr_rdata_o = '0;
        if (csr_req_i) begin
            case (csr_addr_i)
                OFFS_TSELECT: csr_rdata_o = tdu_data_t'(tsel_q);
                OFFS_TDATA1:  csr_rdata_o = tdata1_rd_i[tsel_q];
                OFFS_TDATA2:  csr_rdata_o = tdata2_rd_i[tsel_q];
                OFFS_TINFO:   csr_rdata_o = tdu_data_t'(1) << MCONTROL_TYPE;
                default:      csr_rdata_o = '0;   // Unknown offset
            endcase
        end
    end

    // Write data for the three write commands
    // --------------------------------------------------
    always_comb begin
        wr_req  = 1'b0;
        wr_data = '0;
        case (csr_cmd_i)
            CMD_WRITE: begin
                wr_req  = 1'b1;
                wr_data = csr_wdata_i;
            end
            CMD_SET: begin
                wr_req  = |csr_wdata_i;          // No write for an empty mask
                wr_data = csr_rdata_o | csr_wdata_i;
            end
            CMD_CLEAR: begin
                wr_req  = |csr_wdata_i;
                wr_data = csr_rdata_o & ~csr_wdata_i;
            end
            default: wr_req = 1'b0;
        endcase
    end

    assign wr_en     = csr_req_i & wr_req;
    assign wr_data_o = wr_data;

    // TSELECT drops out of range values
    assign tsel_upd = wr_en & (csr_addr_i == OFFS_TSELECT)
                    & (wr_data < tdu_data_t'(MTRIG_NUM));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tsel_q <= '0;
        end else if (tsel_upd) begin
            tsel_q <= wr_data[TSEL_W-1:0];
        end
    end

    // Per trigger write strobes
    // --------------------------------------------------
    always_comb begin
        sel_onehot         = '0;
        sel_onehot[tsel_q] = 1'b1;
    end

    assign tdata1_we_o = (wr_en && csr_addr_i == OFFS_TDATA1) ? sel_onehot : '0;
    assign tdata2_we_o = (wr_en && csr_addr_i == OFFS_TDATA2) ? sel_onehot : '0;

endmodule

/* src/tdu_mcontrol_trig.sv */
// One mcontrol address match trigger with its TDATA1 fields and TDATA2
// Picks its own slot out of the bank wide strobe and retire vectors

`timescale 1ns/1ps

module tdu_mcontrol_trig #(
    parameter int unsigned MTRIG_NUM = 4,
    parameter int unsigned TRIG_IDX  = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tdu_dsbl_i,

    input  logic [MTRIG_NUM-1:0]    tdata1_we_i,
    input  logic [MTRIG_NUM-1:0]    tdata2_we_i,
    input  tdu_csr_pkg::tdu_data_t  wr_data_i,
    output tdu_csr_pkg::tdu_data_t  tdata1_rd_o,
    output tdu_csr_pkg::tdu_data_t  tdata2_rd_o,

    input  logic                    imon_vd_i,
    input  tdu_trig_pkg::mem_addr_t imon_addr_i,
    input  logic                    dmon_vd_i,
    input  logic                    dmon_load_i,
    input  logic                    dmon_store_i,
    input  tdu_trig_pkg::mem_addr_t dmon_addr_i,
    input  logic [MTRIG_NUM-1:0]    bp_retire_i,

    output logic                    exec_hit_o,
    output logic                    ldst_hit_o,
    output logic                    dmode_req_o
);

    import tdu_csr_pkg::*;
    import tdu_trig_pkg::*;

    logic         dmode_q, m_q, exec_q, load_q, store_q, hit_q;
    trig_action_e action_q;
    tdu_data_t    tdata2_q;
    logic         wr_unlocked;
    logic         t1_wr, t2_wr;

    // A debug mode trigger is writable only while the unit is disabled
    assign wr_unlocked = ~dmode_q | tdu_dsbl_i;
    assign t1_wr       = tdata1_we_i[TRIG_IDX] & wr_unlocked;
    assign t2_wr       = tdata2_we_i[TRIG_IDX] & wr_unlocked;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmode_q  <= 1'b0;
            m_q      <= 1'b0;
            exec_q   <= 1'b0;
            load_q   <= 1'b0;
            store_q  <= 1'b0;
            hit_q    <= 1'b0;
            action_q <= ACT_BREAK_EXC;
            tdata2_q <= '0;
        end else begin
            if (t1_wr) begin
                dmode_q  <= wr_data_i[DMODE_BIT];
                m_q      <= wr_data_i[M_BIT];
                exec_q   <= wr_data_i[EXEC_BIT];
                load_q   <= wr_data_i[LOAD_BIT];
                store_q  <= wr_data_i[STORE_BIT];
                hit_q    <= wr_data_i[HIT_BIT];   // CSR write wins over retire
                action_q <= (wr_data_i[ACTION_HI:ACTION_LO] == 6'd1) ? ACT_DEBUG_MODE
                                                                      : ACT_BREAK_EXC;
            end else if (bp_retire_i[TRIG_IDX]) begin
                hit_q <= 1'b1;
            end
            if (t2_wr) begin
                tdata2_q <= wr_data_i;
            end
        end
    end

    // TDATA1 image
    // --------------------------------------------------
    always_comb begin
        tdata1_rd_o                       = '0;
        tdata1_rd_o[TYPE_HI:TYPE_LO]       = MCONTROL_TYPE;
        tdata1_rd_o[DMODE_BIT]             = dmode_q;
        tdata1_rd_o[MASKMAX_HI:MASKMAX_LO] = MASKMAX_VAL;
        tdata1_rd_o[HIT_BIT]               = hit_q;
        tdata1_rd_o[SELECT_BIT]            = SELECT_VAL;
        tdata1_rd_o[TIMING_BIT]            = TIMING_VAL;
        tdata1_rd_o[ACTION_HI:ACTION_LO]   = 6'(action_q);
        tdata1_rd_o[CHAIN_BIT]             = CHAIN_VAL;
        tdata1_rd_o[MATCH_HI:MATCH_LO]     = MATCH_VAL;
        tdata1_rd_o[M_BIT]                 = m_q;
        tdata1_rd_o[RSVD_HI:RSVD_LO]       = RSVD_VAL;
        tdata1_rd_o[EXEC_BIT]              = exec_q;
        tdata1_rd_o[STORE_BIT]             = store_q;
        tdata1_rd_o[LOAD_BIT]              = load_q;
    end

    assign tdata2_rd_o = tdata2_q;

    // Address compare
    assign exec_hit_o = ~tdu_dsbl_i & m_q & exec_q & imon_vd_i
                      & (imon_addr_i == tdata2_q);
    assign ldst_hit_o = ~tdu_dsbl_i & m_q & dmon_vd_i
                      & ((load_q & dmon_load_i) | (store_q & dmon_store_i))
                      & (dmon_addr_i == tdata2_q);

    assign dmode_req_o = (action_q == ACT_DEBUG_MODE) & bp_retire_i[TRIG_IDX];

endmodule

/* src/tdu_trig_bank.sv */
// Bank of mcontrol triggers
// Collects per trigger hits into match vectors and request lines

`timescale 1ns/1ps

module tdu_trig_bank #(
    parameter int unsigned MTRIG_NUM = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    tdu_dsbl_i,

    input  logic [MTRIG_NUM-1:0]                    tdata1_we_i,
    input  logic [MTRIG_NUM-1:0]                    tdata2_we_i,
    input  tdu_csr_pkg::tdu_data_t                  wr_data_i,
    output tdu_csr_pkg::tdu_data_t [MTRIG_NUM-1:0]  tdata1_rd_o,
    output tdu_csr_pkg::tdu_data_t [MTRIG_NUM-1:0]  tdata2_rd_o,

    input  logic                                    imon_vd_i,
    input  tdu_trig_pkg::mem_addr_t                 imon_addr_i,
    input  logic                                    dmon_vd_i,
    input  logic                                    dmon_load_i,
    input  logic                                    dmon_store_i,
    input  tdu_trig_pkg::mem_addr_t                 dmon_addr_i,
    input  logic [MTRIG_NUM-1:0]                    bp_retire_i,

    output logic [MTRIG_NUM-1:0]                    ibrkpt_match_o,
    output logic                                    ibrkpt_exc_req_o,
    output logic [MTRIG_NUM-1:0]                    dbrkpt_match_o,
    output logic                                    dbrkpt_exc_req_o,
    output logic                                    dmode_req_o
);

    import tdu_csr_pkg::*;
    import tdu_trig_pkg::*;

    logic [MTRIG_NUM-1:0] dmode_vec;   // Debug entry request per trigger

    for (genvar i = 0; i < MTRIG_NUM; i++) begin : gen_trig
        tdu_mcontrol_trig #(
            .MTRIG_NUM (MTRIG_NUM),
            .TRIG_IDX  (i)
        ) trig_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .tdu_dsbl_i   (tdu_dsbl_i),
            .tdata1_we_i  (tdata1_we_i),
            .tdata2_we_i  (tdata2_we_i),
            .wr_data_i    (wr_data_i),
            .tdata1_rd_o  (tdata1_rd_o[i]),
            .tdata2_rd_o  (tdata2_rd_o[i]),
            .imon_vd_i    (imon_vd_i),
            .imon_addr_i  (imon_addr_i),
            .dmon_vd_i    (dmon_vd_i),
            .dmon_load_i  (dmon_load_i),
            .dmon_store_i (dmon_store_i),
            .dmon_addr_i  (dmon_addr_i),
            .bp_retire_i  (bp_retire_i),
            .exec_hit_o   (ibrkpt_match_o[i]),
            .ldst_hit_o   (dbrkpt_match_o[i]),
            .dmode_req_o  (dmode_vec[i])
        );
    end

    // Any hit raises the matching exception request
    assign ibrkpt_exc_req_o = |ibrkpt_match_o;
    assign dbrkpt_exc_req_o = |dbrkpt_match_o;
    assign dmode_req_o      = |dmode_vec;

endmodule

/* src/tdu_top.sv */
// Top level of the trigger debug unit
// Connects the CSR front end to the trigger bank

`timescale 1ns/1ps

module tdu_top #(
    parameter int unsigned MTRIG_NUM = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tdu_dsbl_i,

    // CSR port
    input  logic                     csr_req_i,
    input  tdu_csr_pkg::csr_cmd_e    csr_cmd_i,
    input  tdu_csr_pkg::csr_offs_t   csr_addr_i,
    input  tdu_csr_pkg::tdu_data_t   csr_wdata_i,
    output tdu_csr_pkg::tdu_data_t   csr_rdata_o,

    // Instruction and data monitors
    input  logic                     imon_vd_i,
    input  tdu_trig_pkg::mem_addr_t  imon_addr_i,
    input  logic                     dmon_vd_i,
    input  logic                     dmon_load_i,
    input  logic                     dmon_store_i,
    input  tdu_trig_pkg::mem_addr_t  dmon_addr_i,
    input  logic [MTRIG_NUM-1:0]     bp_retire_i,

    output logic [MTRIG_NUM-1:0]     ibrkpt_match_o,
    output logic                     ibrkpt_exc_req_o,
    output logic [MTRIG_NUM-1:0]     dbrkpt_match_o,
    output logic                     dbrkpt_exc_req_o,
    output logic                     dmode_req_o
);

    import tdu_csr_pkg::*;
    import tdu_trig_pkg::*;

    logic [MTRIG_NUM-1:0]      tdata1_we;
    logic [MTRIG_NUM-1:0]      tdata2_we;
    tdu_data_t                 wr_data;
    tdu_data_t [MTRIG_NUM-1:0] tdata1_rd;
    tdu_data_t [MTRIG_NUM-1:0] tdata2_rd;

    tdu_csr_if #(
        .MTRIG_NUM (MTRIG_NUM)
    ) csr_if_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_req_i   (csr_req_i),
        .csr_cmd_i   (csr_cmd_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .tdata1_rd_i (tdata1_rd),
        .tdata2_rd_i (tdata2_rd),
        .tdata1_we_o (tdata1_we),
        .tdata2_we_o (tdata2_we),
        .wr_data_o   (wr_data)
    );

    tdu_trig_bank #(
        .MTRIG_NUM (MTRIG_NUM)
    ) trig_bank_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .tdu_dsbl_i       (tdu_dsbl_i),
        .tdata1_we_i      (tdata1_we),
        .tdata2_we_i      (tdata2_we),
        .wr_data_i        (wr_data),
        .tdata1_rd_o      (tdata1_rd),
        .tdata2_rd_o      (tdata2_rd),
        .imon_vd_i        (imon_vd_i),
        .imon_addr_i      (imon_addr_i),
        .dmon_vd_i        (dmon_vd_i),
        .dmon_load_i      (dmon_load_i),
        .dmon_store_i     (dmon_store_i),
        .dmon_addr_i      (dmon_addr_i),
        .bp_retire_i      (bp_retire_i),
        .ibrkpt_match_o   (ibrkpt_match_o),
        .ibrkpt_exc_req_o (ibrkpt_exc_req_o),
        .dbrkpt_match_o   (dbrkpt_match_o),
        .dbrkpt_exc_req_o (dbrkpt_exc_req_o),
        .dmode_req_o      (dmode_req_o)
    );

endmodule

/* verification/tdu_properties.sv */
// Concurrent checks on the trigger debug unit ports
// Attached to every tdu_top instance through bind

`timescale 1ns/1ps

module tdu_properties #(
    parameter int unsigned MTRIG_NUM = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 tdu_dsbl_i,
    input logic                 csr_req_i,
    input logic                 imon_vd_i,
    input logic                 dmon_vd_i,
    input logic                 dmon_load_i,
    input logic                 dmon_store_i,
    input logic [MTRIG_NUM-1:0] bp_retire_i,
    input logic [MTRIG_NUM-1:0] ibrkpt_match_i,
    input logic                 ibrkpt_exc_req_i,
    input logic [MTRIG_NUM-1:0] dbrkpt_match_i,
    input logic                 dbrkpt_exc_req_i,
    input logic                 dmode_req_i
);

    // Control inputs must be driven once reset is released
    a_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({tdu_dsbl_i, csr_req_i, imon_vd_i, dmon_vd_i,
                     dmon_load_i, dmon_store_i, bp_retire_i}))
        else $error("control input is X or Z after reset");

    a_iexc_req: assert property (@(posedge clk) disable iff (!rst_n)
        ibrkpt_exc_req_i == (|ibrkpt_match_i))
        else $error("ibrkpt_exc_req_o disagrees with ibrkpt_match_o");

    a_dexc_req: assert property (@(posedge clk) disable iff (!rst_n)
        dbrkpt_exc_req_i == (|dbrkpt_match_i))
        else $error("dbrkpt_exc_req_o disagrees with dbrkpt_match_o");

    // Debug entry only on a retiring breakpoint
    a_dmode_retire: assert property (@(posedge clk) disable iff (!rst_n)
        dmode_req_i |-> (|bp_retire_i))
        else $error("dmode_req_o high without any bp_retire_i bit");

endmodule

bind tdu_top tdu_properties #(
    .MTRIG_NUM (MTRIG_NUM)
) props_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .tdu_dsbl_i       (tdu_dsbl_i),
    .csr_req_i        (csr_req_i),
    .imon_vd_i        (imon_vd_i),
    .dmon_vd_i        (dmon_vd_i),
    .dmon_load_i      (dmon_load_i),
    .dmon_store_i     (dmon_store_i),
    .bp_retire_i      (bp_retire_i),
    .ibrkpt_match_i   (ibrkpt_match_o),
    .ibrkpt_exc_req_i (ibrkpt_exc_req_o),
    .dbrkpt_match_i   (dbrkpt_match_o),
    .dbrkpt_exc_req_i (dbrkpt_exc_req_o),
    .dmode_req_i      (dmode_req_o)
);

/* verification/tdu_tb.sv */
// Directed testbench for the trigger debug unit
// Drives CSR and monitor ports of tdu_top and checks every response

`timescale 1ns/1ps

module tdu_tb;

    import tdu_csr_pkg::*;
    import tdu_trig_pkg::*;

    localparam int MTRIG_NUM   = 4;
    localparam int TEST_CYCLES = 400;              // Rough length of all tests
    localparam int MAX_CYCLES  = 5 * TEST_CYCLES;

    typedef logic [MTRIG_NUM-1:0] trig_vec_t;

    // TDATA1 write values
    localparam tdu_data_t T1_DMODE = 32'h0800_0000;
    localparam tdu_data_t T1_ACT1  = 32'h0000_1000;
    localparam tdu_data_t T1_ACT3  = 32'h0000_3000;
    localparam tdu_data_t T1_M     = 32'h0000_0040;
    localparam tdu_data_t T1_EXEC  = 32'h0000_0004;
    localparam tdu_data_t T1_LOAD  = 32'h0000_0001;

    logic      clk;
    logic      rst_n;
    logic      tdu_dsbl;
    logic      csr_req;
    csr_cmd_e  csr_cmd;
    csr_offs_t csr_addr;
    tdu_data_t csr_wdata;
    tdu_data_t csr_rdata;
    logic      imon_vd;
    mem_addr_t imon_addr;
    logic      dmon_vd;
    logic      dmon_load;
    logic      dmon_store;
    mem_addr_t dmon_addr;
    trig_vec_t bp_retire;
    trig_vec_t ibrkpt_match;
    logic      ibrkpt_exc_req;
    trig_vec_t dbrkpt_match;
    logic      dbrkpt_exc_req;
    logic      dmode_req;

    logic [15:0] lfsr_q    = 16'd47;
    int          cycle_cnt = 0;

    tdu_top #(
        .MTRIG_NUM (MTRIG_NUM)
    ) dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .tdu_dsbl_i       (tdu_dsbl),
        .csr_req_i        (csr_req),
        .csr_cmd_i        (csr_cmd),
        .csr_addr_i       (csr_addr),
        .csr_wdata_i      (csr_wdata),
        .csr_rdata_o      (csr_rdata),
        .imon_vd_i        (imon_vd),
        .imon_addr_i      (imon_addr),
        .dmon_vd_i        (dmon_vd),
        .dmon_load_i      (dmon_load),
        .dmon_store_i     (dmon_store),
        .dmon_addr_i      (dmon_addr),
        .bp_retire_i      (bp_retire),
        .ibrkpt_match_o   (ibrkpt_match),
        .ibrkpt_exc_req_o (ibrkpt_exc_req),
        .dbrkpt_match_o   (dbrkpt_match),
        .dbrkpt_exc_req_o (dbrkpt_exc_req),
        .dmode_req_o      (dmode_req)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Test FAILED");
            $fatal(1, "Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    // Random source and expected values
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic mem_addr_t rand_addr();
        mem_addr_t a;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            a[i]   = lfsr_q[0];
        end
        return a;
    endfunction

    // Expected mcontrol image with type 2 and all other constant fields zero
    function automatic tdu_data_t mcontrol_image(input logic dmode, input logic hit,
                                                 input logic act1, input logic m,
                                                 input logic ex, input logic ld);
        tdu_data_t v;
        v            = 32'h2000_0000;
        v[DMODE_BIT] = dmode;
        v[HIT_BIT]   = hit;
        v[ACTION_LO] = act1;
        v[M_BIT]     = m;
        v[EXEC_BIT]  = ex;
        v[LOAD_BIT]  = ld;
        return v;
    endfunction

    // Compare tasks
    // --------------------------------------------------
    task automatic check_data(input string name, input tdu_data_t exp, input tdu_data_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_mask(input string name, input trig_vec_t exp, input trig_vec_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Bus drivers that change inputs 1 ns after the edge
    // --------------------------------------------------
    task automatic csr_write(input csr_cmd_e cmd, input csr_offs_t addr, input tdu_data_t data);
        @(posedge clk);
        #1;
        csr_req   = 1'b1;
        csr_cmd   = cmd;
        csr_addr  = addr;
        csr_wdata = data;
        @(posedge clk);               // Write lands here
        #1;
        csr_req   = 1'b0;
        csr_cmd   = CMD_NONE;
    endtask

    task automatic csr_read(input csr_offs_t addr, output tdu_data_t data);
        @(posedge clk);
        #1;
        csr_req  = 1'b1;
        csr_cmd  = CMD_NONE;
        csr_addr = addr;
        @(negedge clk);
        data = csr_rdata;
    endtask

    task automatic apply_imon(input logic dsbl, input logic vd, input mem_addr_t addr);
        @(posedge clk);
        #1;
        tdu_dsbl  = dsbl;
        imon_vd   = vd;
        imon_addr = addr;
        @(negedge clk);
    endtask

    task automatic apply_dmon(input logic ld, input logic st, input mem_addr_t addr);
        @(posedge clk);
        #1;
        dmon_vd    = ld | st;
        dmon_load  = ld;
        dmon_store = st;
        dmon_addr  = addr;
        @(negedge clk);
    endtask

    task automatic set_disable(input logic v);
        @(posedge clk);
        #1;
        tdu_dsbl = v;
    endtask

    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_values();
        tdu_data_t rd;
        csr_read(OFFS_TSELECT, rd);
        check_data("reset_tselect", 32'd0, rd);
        csr_read(OFFS_TDATA1, rd);
        check_data("reset_tdata1", 32'h2000_0000, rd);
        csr_read(OFFS_TDATA2, rd);
        check_data("reset_tdata2", 32'd0, rd);
        csr_read(OFFS_TINFO, rd);
        check_data("reset_tinfo", 32'd4, rd);
        csr_read(3'd3, rd);
        check_data("unknown_offset", 32'd0, rd);
        @(posedge clk);
        #1;
        csr_req  = 1'b0;                             // Idle port reads zero
        csr_addr = OFFS_TINFO;
        @(negedge clk);
        check_data("idle_read", 32'd0, csr_rdata);
        csr_write(CMD_WRITE, OFFS_TSELECT, 32'd2);
        csr_read(OFFS_TSELECT, rd);
        check_data("tselect_write", 32'd2, rd);
        csr_write(CMD_WRITE, OFFS_TSELECT, 32'd4);   // Out of range
        csr_read(OFFS_TSELECT, rd);
        check_data("tselect_range", 32'd2, rd);
    endtask

    task automatic test_tdata1_commands();
        tdu_data_t rd;
        csr_write(CMD_WRITE, OFFS_TSELECT, 32'd1);
        csr_write(CMD_WRITE, OFFS_TDATA1, 32'hF7FF_FFFF);   // All but DMODE
        csr_read(OFFS_TDATA1, rd);
        check_data("t1_write_ones", mcontrol_image(0, 1, 0, 1, 1, 1) | 32'h2, rd);
        csr_write(CMD_WRITE, OFFS_TDATA1, T1_ACT3 | T1_M);
        csr_read(OFFS_TDATA1, rd);
        check_data("t1_action3", mcontrol_image(0, 0, 0, 1, 0, 0), rd);
        csr_write(CMD_WRITE, OFFS_TDATA1, T1_ACT1 | T1_M | T1_EXEC);
        csr_read(OFFS_TDATA1, rd);
        check_data("t1_action1", mcontrol_image(0, 0, 1, 1, 1, 0), rd);
        csr_write(CMD_SET, OFFS_TDATA1, T1_LOAD);
        csr_read(OFFS_TDATA1, rd);
        check_data("t1_set", mcontrol_image(0, 0, 1, 1, 1, 1), rd);
        csr_write(CMD_CLEAR, OFFS_TDATA1, T1_EXEC);
        csr_read(OFFS_TDATA1, rd);
        check_data("t1_clear", mcontrol_image(0, 0, 1, 1, 0, 1), rd);
        csr_write(CMD_CLEAR, OFFS_TDATA1, 32'd0);   // Empty mask writes nothing
        csr_read(OFFS_TDATA1, rd);
        check_data("t1_clear_zero", mcontrol_image(0, 0, 1, 1, 0, 1), rd);
        csr_write(CMD_WRITE, OFFS_TDATA1, 32'd0);
        csr_read(OFFS_TDATA1, rd);
        check_data("t1_write_zero", 32'h2000_0000, rd);
    endtask

    task automatic test_exec_breakpoints();
        mem_addr_t addr;
        for (int t = 0; t < MTRIG_NUM; t++) begin
            addr = rand_addr();
            csr_write(CMD_WRITE, OFFS_TSELECT, tdu_data_t'(t));
            csr_write(CMD_WRITE, OFFS_TDATA2, addr);
            csr_write(CMD_WRITE, OFFS_TDATA1, T1_M | T1_EXEC);
            apply_imon(1'b0, 1'b1, addr);
            check_mask("exec_match", trig_vec_t'(1 << t), ibrkpt_match);
            check_bit("exec_exc_req", 1'b1, ibrkpt_exc_req);
            apply_imon(1'b0, 1'b1, addr ^ 32'h10);
            check_mask("exec_other_addr", '0, ibrkpt_match);
            check_bit("exec_other_req", 1'b0, ibrkpt_exc_req);
            apply_imon(1'b1, 1'b1, addr);            // Unit disabled
            check_mask("exec_disabled", '0, ibrkpt_match);
            apply_imon(1'b0, 1'b0, '0);
            csr_write(CMD_WRITE, OFFS_TDATA1, 32'd0);
        end
    endtask

    task automatic test_watchpoint();
        mem_addr_t addr;
        addr = rand_addr();
        csr_write(CMD_WRITE, OFFS_TSELECT, 32'd2);
        csr_write(CMD_WRITE, OFFS_TDATA2, addr);
        csr_write(CMD_WRITE, OFFS_TDATA1, T1_M | T1_LOAD);
        apply_dmon(1'b1, 1'b0, addr);
        check_mask("load_match", 4'b0100, dbrkpt_match);
        check_bit("load_exc_req", 1'b1, dbrkpt_exc_req);
        check_mask("load_no_exec", '0, ibrkpt_match);
        apply_dmon(1'b0, 1'b1, addr);
        check_mask("store_no_match", '0, dbrkpt_match);
        check_bit("store_no_req", 1'b0, dbrkpt_exc_req);
        apply_dmon(1'b0, 1'b0, '0);
        csr_write(CMD_WRITE, OFFS_TDATA1, 32'd0);
    endtask

    task automatic pulse_retire(input int idx, input logic exp_dmode);
        @(posedge clk);
        #1;
        bp_retire = trig_vec_t'(1 << idx);
        @(negedge clk);
        check_bit("retire_dmode_req", exp_dmode, dmode_req);
        @(posedge clk);                              // Hit flag set here
        #1;
        bp_retire = '0;
    endtask

    task automatic test_retire();
        tdu_data_t rd;
        csr_write(CMD_WRITE, OFFS_TSELECT, 32'd3);
        csr_write(CMD_WRITE, OFFS_TDATA1, T1_M | T1_EXEC);
        pulse_retire(3, 1'b0);
        csr_read(OFFS_TDATA1, rd);
        check_data("retire_hit_exc", mcontrol_image(0, 1, 0, 1, 1, 0), rd);
        csr_write(CMD_WRITE, OFFS_TDATA1, T1_ACT1 | T1_M);
        pulse_retire(3, 1'b1);
        csr_read(OFFS_TDATA1, rd);
        check_data("retire_hit_dbg", mcontrol_image(0, 1, 1, 1, 0, 0), rd);
        pulse_retire(0, 1'b0);                       // Trigger 0 has action 0
        csr_write(CMD_WRITE, OFFS_TDATA1, 32'd0);
    endtask

    task automatic test_dmode_lock();
        tdu_data_t rd;
        csr_write(CMD_WRITE, OFFS_TSELECT, 32'd1);
        csr_write(CMD_WRITE, OFFS_TDATA2, 32'h1234_5678);
        csr_write(CMD_WRITE, OFFS_TDATA1, T1_DMODE | T1_M | T1_EXEC);
        csr_write(CMD_WRITE, OFFS_TDATA2, 32'hDEAD_BEEF);
        csr_read(OFFS_TDATA2, rd);
        check_data("lock_tdata2", 32'h1234_5678, rd);
        csr_write(CMD_WRITE, OFFS_TDATA1, 32'd0);
        csr_read(OFFS_TDATA1, rd);
        check_data("lock_tdata1", mcontrol_image(1, 0, 0, 1, 1, 0), rd);
        set_disable(1'b1);
        csr_write(CMD_WRITE, OFFS_TDATA2, 32'hCAFE_F00D);
        csr_read(OFFS_TDATA2, rd);
        check_data("unlock_tdata2", 32'hCAFE_F00D, rd);
        csr_write(CMD_WRITE, OFFS_TDATA1, 32'd0);
        csr_read(OFFS_TDATA1, rd);
        check_data("unlock_tdata1", 32'h2000_0000, rd);
        set_disable(1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        tdu_dsbl   = 1'b0;
        csr_req    = 1'b0;
        csr_cmd    = CMD_NONE;
        csr_addr   = '0;
        csr_wdata  = '0;
        imon_vd    = 1'b0;
        imon_addr  = '0;
        dmon_vd    = 1'b0;
        dmon_load  = 1'b0;
        dmon_store = 1'b0;
        dmon_addr  = '0;
        bp_retire  = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_values();
        test_tdata1_commands();
        test_exec_breakpoints();
        test_watchpoint();
        test_retire();
        test_dmode_lock();

        $display("Test OK");
        $finish;
    end

endmodule

/* src.f */
src/tdu_csr_pkg.sv
src/tdu_trig_pkg.sv
src/tdu_csr_if.sv
src/tdu_mcontrol_trig.sv
src/tdu_trig_bank.sv
src/tdu_top.sv
verification/tdu_properties.sv
verification/tdu_tb.sv

/* Makefile */
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP   ?= tdu_tb
FLIST ?= src.f
BUILD ?= obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
